/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/alu.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module alu (
  input  core_pkg::alu_op_e op,
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  output core_pkg::word_t   result
);

  core_pkg::shamt_t shamt;
  core_pkg::word_t  sum;
  core_pkg::word_t  diff;
  logic             lt_signed;
  logic             lt_unsigned;

  // divide chain where entry i feeds stage i
  core_pkg::word_t div_dividend  [0:`DIV_STAGES];
  core_pkg::word_t div_remainder [0:`DIV_STAGES];
  core_pkg::word_t div_quotient  [0:`DIV_STAGES];

  assign shamt       = b[4:0];
  assign sum         = a + b;
  assign diff        = a - b;
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // operand stage of the divider
  assign div_dividend[0]  = a;
  assign div_remainder[0] = '0;
  assign div_quotient[0]  = '0;

  generate
    for (genvar i = 0; i < `DIV_STAGES; i++) begin : g_div
      divu_stage u_stage (
        .dividend_in   (div_dividend[i]),
        .remainder_in  (div_remainder[i]),
        .quotient_in   (div_quotient[i]),
        .divisor       (b),
        .dividend_out  (div_dividend[i+1]),
        .remainder_out (div_remainder[i+1]),
        .quotient_out  (div_quotient[i+1])
      );
    end
  endgenerate

  always_comb begin
    case (op)
      core_pkg::ALU_ADD:    result = sum;
      core_pkg::ALU_SUB:    result = diff;
      core_pkg::ALU_SLL:    result = a << shamt;
      core_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
      core_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      core_pkg::ALU_XOR:    result = a ^ b;
      core_pkg::ALU_SRL:    result = a >> shamt;
      core_pkg::ALU_SRA:    result = core_pkg::word_t'($signed(a) >>> shamt);
      core_pkg::ALU_OR:     result = a | b;
      core_pkg::ALU_AND:    result = a & b;
      core_pkg::ALU_PASS_B: result = b;
      core_pkg::ALU_DIVU:   result = div_quotient[`DIV_STAGES];
      core_pkg::ALU_REMU:   result = div_remainder[`DIV_STAGES];
      default:              result = '0;
    endcase
  end

  // holds only if every stage restored correctly
  always_comb begin
    if (b != '0) begin
      a_rem_below_divisor: assert (div_remainder[`DIV_STAGES] < b)
        else $error("divide chain remainder %h not below divisor %h",
                    div_remainder[`DIV_STAGES], b);
    end
  end

endmodule

/* hw/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath word width
`define XLEN 32

// architectural register count
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// sequential fetch increment, one word
`define PC_STEP 32'd4

// one restoring step per quotient bit
`define DIV_STAGES `XLEN

`endif

/* hw/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] word_t;

  // low five bits of operand b
  typedef logic [4:0] shamt_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_DIVU,
    ALU_REMU
  } alu_op_e;

  // values match the branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

endpackage

/* hw/divu_stage.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module divu_stage (
  input  core_pkg::word_t dividend_in,
  input  core_pkg::word_t remainder_in,
  input  core_pkg::word_t quotient_in,
  input  core_pkg::word_t divisor,
  output core_pkg::word_t dividend_out,
  output core_pkg::word_t remainder_out,
  output core_pkg::word_t quotient_out
);

  // one extra bit so the shifted remainder never overflows
  logic [`XLEN:0] partial;
  logic [`XLEN:0] trial;

  assign partial = {remainder_in, dividend_in[`XLEN-1]};
  assign trial   = partial - {1'b0, divisor};

  assign dividend_out = {dividend_in[`XLEN-2:0], 1'b0};

  // borrow out means partial was below divisor, so restore
  assign remainder_out = trial[`XLEN] ? partial[`XLEN-1:0] : trial[`XLEN-1:0];
  assign quotient_out  = {quotient_in[`XLEN-2:0], ~trial[`XLEN]};

endmodule

/* hw/insn_decode.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module insn_decode (
  input  rv_isa_pkg::insn_t     insn,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output logic                  rd_we,
  output core_pkg::word_t       imm,
  output core_pkg::alu_op_e     alu_op,
  output logic                  use_imm,
  output core_pkg::pc_sel_e     pc_sel,
  output core_pkg::br_cond_e    br_cond,
  output logic                  link_wb,
  output logic                  ecall
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_b;
  core_pkg::word_t     imm_j;
  core_pkg::word_t     imm_u;
  logic                writes;

  // shared funct3 mapping of OP and OP_IMM
  function automatic core_pkg::alu_op_e base_op(input rv_isa_pkg::funct3_t f3);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: base_op = core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     base_op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     base_op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    base_op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     base_op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: base_op = core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      base_op = core_pkg::ALU_OR;
      rv_isa_pkg::F3_AND:     base_op = core_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = rv_isa_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  // sign extended from bit 31
  assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(`XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(`XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], {(`XLEN-20){1'b0}}};

  always_comb begin
    writes  = 1'b0;
    imm     = imm_i;
    alu_op  = core_pkg::ALU_ADD;
    use_imm = 1'b0;
    pc_sel  = core_pkg::PC_SEQ;
    br_cond = core_pkg::BR_EQ;
    link_wb = 1'b0;
    ecall   = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        writes = 1'b1;
        if (funct7 == rv_isa_pkg::F7_BASE) begin
          alu_op = base_op(funct3);
        end else if (funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          alu_op = core_pkg::ALU_SUB;
        end else if (funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          alu_op = core_pkg::ALU_SRA;
        end else if (funct7 == rv_isa_pkg::F7_MULDIV && funct3 == rv_isa_pkg::F3_DIVU) begin
          alu_op = core_pkg::ALU_DIVU;
        end else if (funct7 == rv_isa_pkg::F7_MULDIV && funct3 == rv_isa_pkg::F3_REMU) begin
          alu_op = core_pkg::ALU_REMU;
        end else begin
          writes = 1'b0;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        writes  = 1'b1;
        use_imm = 1'b1;
        alu_op  = base_op(funct3);
        // shifts reuse the funct7 slot of the immediate
        if (funct3 == rv_isa_pkg::F3_SLL && funct7 != rv_isa_pkg::F7_BASE) begin
          writes = 1'b0;
        end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          if (funct7 == rv_isa_pkg::F7_ALT) begin
            alu_op = core_pkg::ALU_SRA;
          end else if (funct7 != rv_isa_pkg::F7_BASE) begin
            writes = 1'b0;
          end
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        writes  = 1'b1;
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = core_pkg::ALU_PASS_B;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        imm = imm_b;
        // funct3 010 and 011 are not branches
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          pc_sel  = core_pkg::PC_BRANCH;
          br_cond = core_pkg::br_cond_e'(funct3);
        end
      end
      rv_isa_pkg::OPC_JAL: begin
        writes  = 1'b1;
        imm     = imm_j;
        pc_sel  = core_pkg::PC_JAL;
        link_wb = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        if (funct3 == rv_isa_pkg::F3_JALR) begin
          writes  = 1'b1;
          pc_sel  = core_pkg::PC_JALR;
          link_wb = 1'b1;
        end
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        ecall = (insn[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

  // x0 is never a write target
  assign rd_we = writes && (rd != '0);

endmodule

/* hw/next_pc.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module next_pc (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::word_t      rs1_data,
  input  core_pkg::word_t      rs2_data,
  input  core_pkg::word_t      imm,
  input  core_pkg::pc_sel_e    pc_sel,
  input  core_pkg::br_cond_e   br_cond,
  input  logic                 ecall,
  output core_pkg::word_t      pc,
  output core_pkg::word_t      link,
  output logic                 halt
);

  logic            taken;
  core_pkg::word_t pc_plus_imm;
  core_pkg::word_t jalr_sum;
  core_pkg::word_t pc_next;

  always_comb begin
    case (br_cond)
      core_pkg::BR_EQ:  taken = rs1_data == rs2_data;
      core_pkg::BR_NE:  taken = rs1_data != rs2_data;
      core_pkg::BR_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
      core_pkg::BR_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      core_pkg::BR_LTU: taken = rs1_data < rs2_data;
      core_pkg::BR_GEU: taken = rs1_data >= rs2_data;
      default:          taken = 1'b0;
    endcase
  end

  assign link        = pc + `PC_STEP;
  assign pc_plus_imm = pc + imm;
  assign jalr_sum    = rs1_data + imm;

  always_comb begin
    case (pc_sel)
      core_pkg::PC_BRANCH: pc_next = taken ? pc_plus_imm : link;
      core_pkg::PC_JAL:    pc_next = pc_plus_imm;
      // target bit 0 is cleared
      core_pkg::PC_JALR:   pc_next = {jalr_sum[`XLEN-1:1], 1'b0};
      default:             pc_next = link;
    endcase
  end

  // ecall parks the core on its own address
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (!ecall) begin
      pc <= pc_next;
    end
  end

  assign halt = ecall;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %h not word aligned", pc);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_isa_pkg::reg_addr_t rd,
  input  logic                  we,
  input  core_pkg::word_t       rd_data,
  output core_pkg::word_t       rs1_data,
  output core_pkg::word_t       rs2_data
);

  core_pkg::word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // asynchronous reads with x0 hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // decode already drops writes to x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) !(we && rd == '0))
    else $error("write enable raised with rd = x0");

endmodule

/* hw/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  output core_pkg::word_t       pc,
  input  rv_isa_pkg::insn_t     insn,
  output logic                  halt,
  output logic                  wb_en,
  output rv_isa_pkg::reg_addr_t wb_rd,
  output core_pkg::word_t       wb_data
);

  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::reg_addr_t rd;
  logic                  rd_we;
  core_pkg::word_t       imm;
  core_pkg::alu_op_e     alu_op;
  logic                  use_imm;
  core_pkg::pc_sel_e     pc_sel;
  core_pkg::br_cond_e    br_cond;
  logic                  link_wb;
  logic                  ecall;
  core_pkg::word_t       rs1_data;
  core_pkg::word_t       rs2_data;
  core_pkg::word_t       op_b;
  core_pkg::word_t       alu_result;
  core_pkg::word_t       link;
  core_pkg::word_t       wb_value;
  logic                  wr_en;

  insn_decode u_decode (
    .insn    (insn),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .rd_we   (rd_we),
    .imm     (imm),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .pc_sel  (pc_sel),
    .br_cond (br_cond),
    .link_wb (link_wb),
    .ecall   (ecall)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (wr_en),
    .rd_data  (wb_value),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign op_b = use_imm ? imm : rs2_data;

  alu u_alu (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (op_b),
    .result (alu_result)
  );

  next_pc u_next_pc (
    .clk      (clk),
    .rst      (rst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc_sel   (pc_sel),
    .br_cond  (br_cond),
    .ecall    (ecall),
    .pc       (pc),
    .link     (link),
    .halt     (halt)
  );

  // jumps write the return address
  assign wb_value = link_wb ? link : alu_result;

  // no commits while halted or held in reset
  assign wr_en = rd_we && !halt && !rst;

  assign wb_en   = wr_en;
  assign wb_rd   = rd;
  assign wb_data = wb_value;

endmodule

/* hw/rv_isa_pkg.sv */
`include "core_defs.svh"

package rv_isa_pkg;

  // raw instruction word
  typedef logic [`XLEN-1:0] insn_t;

  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct7 groups
  localparam funct7_t F7_BASE   = 7'b0000000;
  localparam funct7_t F7_ALT    = 7'b0100000;
  localparam funct7_t F7_MULDIV = 7'b0000001;

  // funct3 for OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // M extension subset
  localparam funct3_t F3_DIVU = 3'b101;
  localparam funct3_t F3_REMU = 3'b111;

  localparam funct3_t F3_JALR = 3'b000;

endpackage

/* sim/rv_core_tb.sv */
`timescale 1ns/100ps
`include "core_defs.svh"

module rv_core_tb;

  localparam int MEM_WORDS = 256;

  logic        clk;
  logic        rst;
  logic [31:0] insn;
  logic [31:0] pc;
  logic        halt;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] rand_state;
  int          prog_len;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          halt_cycles;
  logic        reset_live;

  // shadow state of the reference model
  logic [31:0] sregs [32];
  logic [31:0] spc;
  logic        exp_valid;
  logic        exp_wb_en;
  logic [4:0]  exp_wb_rd;
  logic [31:0] exp_wb_data;
  logic        exp_halt;
  logic [31:0] exp_next_pc;

  rv_core rv_core_inst (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .insn    (insn),
    .halt    (halt),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          tgt;
    // custom-0 opcode everywhere else so stray fetches retire nothing
    for (int k = 0; k < MEM_WORDS; k++) begin
      imem[k] = {8'(k), ~8'(k), 8'(k), 8'h0b};
    end
    prog_len = 0;
    for (int k = 1; k <= 8; k++) begin
      r = next_rand();
      emit({r[31:12], 5'(k), 7'b0110111});
      r = next_rand();
      emit(enc_i(r[11:0], 5'(k), 3'b000, 5'(k), 7'b0010011));
    end
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd9, 7'b0010011));
    // small divisor, then divide by zero
    emit(enc_r(7'h01, 5'd9, 5'd1, 3'b101, 5'd10));
    emit(enc_r(7'h01, 5'd9, 5'd1, 3'b111, 5'd11));
    emit(enc_r(7'h01, 5'd0, 5'd2, 3'b101, 5'd10));
    emit(enc_r(7'h01, 5'd0, 5'd2, 3'b111, 5'd11));
    // x0 targets, then reads of x0
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    emit(enc_i(12'h555, 5'd3, 3'b110, 5'd0, 7'b0010011));
    emit(enc_r(7'h00, 5'd0, 5'd3, 3'b000, 5'd16));
    emit(enc_i(12'h000, 5'd0, 3'b000, 5'd17, 7'b0010011));
    for (int k = 0; k < 30; k++) begin
      r = next_rand();
      if (r[31]) begin
        case (r[15:12] % 12)
          0: {f7, f3} = {7'h00, 3'd0};
          1: {f7, f3} = {7'h20, 3'd0};
          2: {f7, f3} = {7'h00, 3'd1};
          3: {f7, f3} = {7'h00, 3'd2};
          4: {f7, f3} = {7'h00, 3'd3};
          5: {f7, f3} = {7'h00, 3'd4};
          6: {f7, f3} = {7'h00, 3'd5};
          7: {f7, f3} = {7'h20, 3'd5};
          8: {f7, f3} = {7'h00, 3'd6};
          9: {f7, f3} = {7'h00, 3'd7};
          10: {f7, f3} = {7'h01, 3'd5};
          default: {f7, f3} = {7'h01, 3'd7};
        endcase
        emit(enc_r(f7, {1'b0, r[11:8]}, {1'b0, r[7:4]}, f3, {1'b0, r[3:0]}));
      end else begin
        f3  = r[14:12];
        imm = r[27:16];
        // shift immediates carry only a shamt and the arithmetic bit
        if (f3 == 3'd1) imm = {7'h00, r[20:16]};
        if (f3 == 3'd5) imm = {r[26] ? 7'h20 : 7'h00, r[20:16]};
        emit(enc_i(imm, {1'b0, r[7:4]}, f3, {1'b0, r[3:0]}, 7'b0010011));
      end
    end
    // each branch kind twice as a self compare then a random pair
    for (int k = 0; k < 6; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      r  = next_rand();
      emit(enc_b(13'd8, {1'b0, r[3:0]}, {1'b0, r[3:0]}, f3));
      emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, 7'b0010011));
      emit(enc_b(13'd8, {1'b0, r[7:4]}, {1'b0, r[11:8]}, f3));
      emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, 7'b0010011));
    end
    emit(enc_j(21'd8, 5'd13));
    emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, 7'b0010011));
    // odd target sum whose bit 0 gets cleared
    tgt = (prog_len + 3) * 4;
    emit(enc_i(12'(tgt), 5'd0, 3'b000, 5'd14, 7'b0010011));
    emit(enc_i(12'd1, 5'd14, 3'b000, 5'd15, 7'b1100111));
    emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, 7'b0010011));
    emit(enc_r(7'h00, 5'd13, 5'd15, 3'b000, 5'd18));
    emit(32'h0000_0073);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // expected outputs of the instruction at spc
  task automatic model_exec(input logic [31:0] i);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic        we;
    logic [31:0] res;
    logic [31:0] npc;
    logic        stop;
    f3    = i[14:12];
    f7    = i[31:25];
    a     = sregs[i[19:15]];
    b     = sregs[i[24:20]];
    imm_i = {{20{i[31]}}, i[31:20]};
    we    = 1'b0;
    res   = 32'h0;
    npc   = spc + 32'd4;
    stop  = 1'b0;
    case (i[6:0])
      7'b0110011: begin
        if (f7 == 7'h01 && (f3 == 3'b101 || f3 == 3'b111)) begin
          we = 1'b1;
          if (f3 == 3'b101) res = (b == 0) ? 32'hffff_ffff : a / b;
          else res = (b == 0) ? a : a % b;
        end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
          we  = 1'b1;
          res = alu_ref(f3, f7[5], a, b);
        end
      end
      7'b0010011: begin
        we  = 1'b1;
        res = alu_ref(f3, f3 == 3'b101 && i[30], a, imm_i);
      end
      7'b0110111: begin
        we  = 1'b1;
        res = {i[31:12], 12'h000};
      end
      7'b1100011: begin
        if (branch_taken(f3, a, b)) begin
          npc = spc + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        we  = 1'b1;
        res = spc + 32'd4;
        npc = spc + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      end
      7'b1100111: begin
        we  = (f3 == 3'b000);
        res = spc + 32'd4;
        if (f3 == 3'b000) npc = (a + imm_i) & ~32'h1;
      end
      7'b1110011: begin
        if (i == 32'h0000_0073) begin
          stop = 1'b1;
          npc  = spc;
        end
      end
      default: begin
      end
    endcase
    exp_wb_en   = we && i[11:7] != 5'd0 && !stop;
    exp_wb_rd   = i[11:7];
    exp_wb_data = res;
    exp_halt    = stop;
    exp_next_pc = npc;
  endtask

  initial begin
    rst         = 1'b1;
    insn        = 32'h0000_0013;
    rand_state  = 32'h8cd6662f;
    errors      = 0;
    cycles      = 0;
    halt_cycles = 0;
    reset_live  = 1'b0;
    exp_valid   = 1'b0;
    exp_wb_en   = 1'b0;
    exp_wb_rd   = 5'd0;
    exp_wb_data = 32'h0;
    exp_halt    = 1'b0;
    exp_next_pc = `RESET_PC;
    build_program();
    cycle_limit = prog_len + 50;
    for (int k = 0; k < 32; k++) begin
      sregs[k] = 32'h0;
    end
    spc = `RESET_PC;
    repeat (16) begin
      @(posedge clk);
      #2;
      reset_live = 1'b1;
      insn       = imem[pc[9:2]];
    end
    rst = 1'b0;
    model_exec(imem[spc[9:2]]);
    exp_valid = 1'b1;
    while (halt_cycles < 4) begin
      @(posedge clk);
      #2;
      // halt still shows the instruction that just retired
      if (halt) halt_cycles++;
      insn = imem[pc[9:2]];
      if (exp_wb_en) sregs[exp_wb_rd] = exp_wb_data;
      spc = exp_next_pc;
      model_exec(imem[spc[9:2]]);
    end
    @(posedge clk);
    #2;
    $display("run finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // limit derived from the program length
  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: core did not halt within %0d cycles, %0d errors so far",
                 cycle_limit, errors);
        $display("TEST RESULT: FAIL");
        $finish;
      end
    end
  end

  reset_state: assert property (@(posedge clk) rst && reset_live |->
                                pc == `RESET_PC && !wb_en && !halt)
    else begin
      errors++;
      $display("Mismatch during reset: pc %h wb_en %h halt %h, expected %h 0 0",
               $sampled(pc), $sampled(wb_en), $sampled(halt), `RESET_PC);
    end

  pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == `RESET_PC)
    else begin
      errors++;
      $display("Mismatch pc after reset: got %h expected %h", $sampled(pc), `RESET_PC);
    end

  pc_follows_model: assert property (@(posedge clk) disable iff (rst) exp_valid |-> pc == spc)
    else begin
      errors++;
      $display("Mismatch pc: got %h expected %h", $sampled(pc), $sampled(spc));
    end

  // also covers every x0 destination
  wb_en_matches: assert property (@(posedge clk) disable iff (rst)
                                  exp_valid |-> wb_en == exp_wb_en)
    else begin
      errors++;
      $display("Mismatch wb_en: got %h expected %h at pc %h",
               $sampled(wb_en), $sampled(exp_wb_en), $sampled(spc));
    end

  wb_fields_match: assert property (@(posedge clk) disable iff (rst)
                                    exp_valid && exp_wb_en |->
                                    wb_rd == exp_wb_rd && wb_data == exp_wb_data)
    else begin
      errors++;
      $display("Mismatch wb_rd/wb_data: got %h/%h expected %h/%h at pc %h",
               $sampled(wb_rd), $sampled(wb_data), $sampled(exp_wb_rd),
               $sampled(exp_wb_data), $sampled(spc));
    end

  halt_matches: assert property (@(posedge clk) disable iff (rst)
                                 exp_valid |-> halt == exp_halt)
    else begin
      errors++;
      $display("Mismatch halt: got %h expected %h", $sampled(halt), $sampled(exp_halt));
    end

  halt_holds: assert property (@(posedge clk) disable iff (rst)
                               $past(halt) |-> halt && pc == $past(pc) && !wb_en)
    else begin
      errors++;
      $display("after ECALL the core dropped halt, moved pc or retired a write");
    end

endmodule

/* verilog.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/divu_stage.sv
hw/alu.sv
hw/insn_decode.sv
hw/reg_file.sv
hw/next_pc.sv
hw/rv_core.sv
sim/rv_core_tb.sv
